//--- verilog.f
hw/isa_pkg.sv
hw/core_pkg.sv
hw/decode_if.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/mem_access.sv
hw/fetch_pc.sv
hw/rv_core.sv
tb/core_checker.sv
tb/tb_rv_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_rv_core \
    -f verilog.f -o tb_rv_core
./obj_dir/tb_rv_core | tee sim.log

if grep -q "TB PASSED" sim.log; then
    exit 0
else
    exit 1
fi

//--- tb/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
    localparam logic [63:0] reset_pc = 64'h0;
    localparam int n_tests = 10;
    localparam logic [31:0] ebreak_inst = 32'h0010_0073;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [63:0] imem_addr;
    logic [31:0] imem_data;
    logic [63:0] dmem_addr;
    logic [63:0] dmem_wdata;
    logic [7:0]  dmem_wmask;
    logic        dmem_wen;
    logic        dmem_ren;
    logic [63:0] dmem_rdata;
    logic        halt;
    logic        illegal;

    logic [31:0] prog [256];
    logic [63:0] dmem [512];  // 4 KiB
    logic [31:0] lfsr_state = 32'hbf1d0f07;

    rv_core #(.reset_pc(reset_pc)) rv_core_i (
        .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_wmask(dmem_wmask),
        .dmem_wen(dmem_wen), .dmem_ren(dmem_ren), .dmem_rdata(dmem_rdata),
        .halt(halt), .illegal(illegal)
    );

    core_checker #(.reset_pc(reset_pc)) core_checker_i (
        .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_wmask(dmem_wmask),
        .dmem_wen(dmem_wen), .dmem_ren(dmem_ren), .halt(halt), .illegal(illegal)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    // memories answer in the same cycle
    assign imem_data  = (imem_addr < 64'd1024) ? prog[imem_addr[9:2]] : ebreak_inst;
    assign dmem_rdata = dmem[dmem_addr[11:3]];

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 512; i++)
                dmem[i] <= core_checker_i.mem_fill(i);
        end else if (dmem_wen) begin
            for (int b = 0; b < 8; b++)
                if (dmem_wmask[b])
                    dmem[dmem_addr[11:3]][8*b +: 8] <= dmem_wdata[8*b +: 8];
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    // stores always use x0 as base
    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic build_program(input int kind);
        int          idx;
        int          cls;
        int          k;
        logic [4:0]  rd;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [11:0] off;
        logic [31:0] w;
        logic        link;
        for (int i = 0; i < 256; i++)
            prog[i] = ebreak_inst;
        idx = 0;
        while (idx < 240) begin
            rd   = 5'(rand_bits(3));
            ra   = 5'(rand_bits(3));
            rb   = 5'(rand_bits(3));
            link = 1'b1;
            if (kind == 0)
                cls = 0;
            else if (kind == 2)
                cls = 2 * int'(rand_bits(1));
            else
                cls = int'(rand_bits(1));  // straight-line code reaches the inserted word
            if (cls == 0) begin
                off = 12'(rand_bits(12));
                case (rand_bits(4) % 9)
                    0: w = enc_r(7'h00, rb, ra, 3'd0, rd, 7'h33);
                    1: w = enc_r(7'h20, rb, ra, 3'd0, rd, 7'h33);
                    2: w = enc_i(off, ra, 3'd0, rd, 7'h13);
                    3: w = enc_i(off, ra, 3'd3, rd, 7'h13);
                    4: w = enc_i({6'b010000, off[5:0]}, ra, 3'd5, rd, 7'h13);  // srai
                    5: w = enc_r(7'h00, rb, ra, 3'd0, rd, 7'h3b);
                    6: w = enc_i(off, ra, 3'd0, rd, 7'h1b);
                    7: w = {20'(rand_bits(20)), rd, 7'h37};
                    default: w = {20'(rand_bits(20)), rd, 7'h17};
                endcase
            end else if (cls == 1) begin
                case (rand_bits(3) % 5)
                    0: w = enc_i(12'(rand_bits(9) << 2), 5'd0, 3'd2, rd, 7'h03);
                    1: w = enc_i(12'(rand_bits(8) << 3), 5'd0, 3'd3, rd, 7'h03);
                    2: w = enc_i(12'(rand_bits(11)), 5'd0, 3'd4, rd, 7'h03);
                    3: begin
                        w    = enc_s(12'(rand_bits(10) << 1), rb, 3'd1);
                        link = 1'b0;
                    end
                    default: begin
                        w    = enc_s(12'(rand_bits(8) << 3), rb, 3'd3);
                        link = 1'b0;
                    end
                endcase
            end else begin
                k = int'(rand_bits(2)) + 1;  // forward by 1 to 4 slots
                case (rand_bits(2))
                    0: begin
                        w    = enc_b(13'(k * 4), ra, rb, 3'd0);
                        link = 1'b0;
                    end
                    1: begin
                        w    = enc_b(13'(k * 4), ra, rb, 3'd1);
                        link = 1'b0;
                    end
                    2: w = enc_j(21'(k * 4), rd);
                    default: w = enc_i(12'((idx + k) * 4), 5'd0, 3'd0, rd, 7'h67);
                endcase
            end
            prog[idx] = w;
            idx++;
            if (link) begin
                prog[idx] = enc_s(12'(rand_bits(8) << 3), rd, 3'd3);
                idx++;
            end
        end
        if (kind == 3)
            prog[8 + int'(rand_bits(7))] = ebreak_inst;
        if (kind == 4) begin
            do
                w = rand_bits(32);
            while (w[6:0] inside {7'h33, 7'h13, 7'h3b, 7'h1b, 7'h03, 7'h23, 7'h6f,
                                  7'h67, 7'h37, 7'h17, 7'h63} || w == ebreak_inst);
            prog[8 + int'(rand_bits(7))] = w;
        end
    endtask

    initial begin
        #(n_tests * (256 + 8 + 20) * 8 * 2);
        $display("timeout: the core never reached halt within the time limit");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        string kind_name;
        rst_n = 1'b0;
        for (int i = 0; i < 256; i++)
            prog[i] = ebreak_inst;
        for (int t = 0; t < n_tests; t++) begin
            @(posedge clk);
            rst_n <= 1'b0;
            build_program(t % 5);
            repeat (8) @(posedge clk);
            rst_n <= 1'b1;
            do
                @(negedge clk);
            while (!halt);
            repeat (20) @(posedge clk);  // halted core must stay frozen
            case (t % 5)
                0: kind_name = "arith";
                1: kind_name = "load_store";
                2: kind_name = "control";
                3: kind_name = "ebreak";
                default: kind_name = "illegal";
            endcase
            core_checker_i.end_test(t, kind_name);
        end
        $display("tests passed %0d, failed %0d, mismatches %0d",
                 core_checker_i.passes, core_checker_i.fails, core_checker_i.errors);
        if (core_checker_i.fails == 0 && core_checker_i.errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end
endmodule

`default_nettype wire

//--- tb/core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module core_checker #(
    parameter logic [63:0] reset_pc = 64'h0
) (
    input wire        clk,
    input wire        rst_n,
    input wire [63:0] imem_addr,
    input wire [31:0] imem_data,
    input wire [63:0] dmem_addr,
    input wire [63:0] dmem_wdata,
    input wire [7:0]  dmem_wmask,
    input wire        dmem_wen,
    input wire        dmem_ren,
    input wire        halt,
    input wire        illegal
);
    logic [63:0] x [32];
    logic [63:0] m_mem [512];
    logic [63:0] m_pc;
    logic        m_halted;
    logic        first;
    int          errors = 0;
    int          errors_at_start = 0;
    int          passes = 0;
    int          fails = 0;

    // initial data contents, shared with the memory model in the testbench
    function automatic logic [63:0] mem_fill(input int idx);
        logic [31:0] a;
        a = idx;
        return {a * 32'h9e3779b1, ~a ^ (a << 13)};
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic step(input logic [31:0] in);
        logic [63:0] r1, r2, ii, is, ib, iu, ij, val, npc, ea, d, wd;
        logic [7:0]  mask;
        logic        bad, ebrk, wr, st, ld;
        r1   = x[in[19:15]];
        r2   = x[in[24:20]];
        ii   = {{52{in[31]}}, in[31:20]};
        is   = {{52{in[31]}}, in[31:25], in[11:7]};
        ib   = {{51{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
        iu   = {{32{in[31]}}, in[31:12], 12'h0};
        ij   = {{43{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
        bad  = 1'b0;
        ebrk = 1'b0;
        wr   = 1'b0;
        st   = 1'b0;
        val  = '0;
        mask = '0;
        wd   = '0;
        npc  = m_pc + 64'd4;
        ea   = r1 + ((in[6:0] == 7'h23) ? is : ii);
        d    = m_mem[ea[11:3]] >> (8 * ea[2:0]);
        case (in[6:0])
            7'h33: begin
                wr = 1'b1;
                if (in[14:12] == 3'd0 && in[31:25] == 7'h00)
                    val = r1 + r2;
                else if (in[14:12] == 3'd0 && in[31:25] == 7'h20)
                    val = r1 - r2;
                else
                    bad = 1'b1;
            end
            7'h13: begin
                wr = 1'b1;
                if (in[14:12] == 3'd0)
                    val = r1 + ii;
                else if (in[14:12] == 3'd3)
                    val = {63'b0, r1 < ii};
                else if (in[14:12] == 3'd5 && in[31:26] == 6'b010000)
                    val = $signed(r1) >>> in[25:20];
                else
                    bad = 1'b1;
            end
            7'h3b: begin
                wr  = 1'b1;
                val = r1 + r2;
                val = {{32{val[31]}}, val[31:0]};
                bad = !(in[14:12] == 3'd0 && in[31:25] == 7'h00);
            end
            7'h1b: begin
                wr  = 1'b1;
                val = r1 + ii;
                val = {{32{val[31]}}, val[31:0]};
                bad = (in[14:12] != 3'd0);
            end
            7'h03: begin
                wr = 1'b1;
                case (in[14:12])
                    3'd2: val = {{32{d[31]}}, d[31:0]};  // lw
                    3'd3: val = d;
                    3'd4: val = {56'b0, d[7:0]};          // lbu
                    default: bad = 1'b1;
                endcase
            end
            7'h23: begin
                st = 1'b1;
                wd = r2 << (8 * ea[2:0]);
                if (in[14:12] == 3'd3)
                    mask = 8'hff;
                else if (in[14:12] == 3'd1)
                    mask = 8'h03 << ea[2:0];
                else begin
                    bad = 1'b1;
                    st  = 1'b0;
                end
            end
            7'h6f: begin
                wr  = 1'b1;
                val = m_pc + 64'd4;
                npc = m_pc + ij;
            end
            7'h67: begin
                wr  = 1'b1;
                val = m_pc + 64'd4;
                npc = (r1 + ii) & ~64'd1;
                bad = (in[14:12] != 3'd0);
            end
            7'h37: begin
                wr  = 1'b1;
                val = iu;
            end
            7'h17: begin
                wr  = 1'b1;
                val = m_pc + iu;
            end
            7'h63: begin
                if (in[14:12] == 3'd0 && r1 == r2)
                    npc = m_pc + ib;
                else if (in[14:12] == 3'd1 && r1 != r2)
                    npc = m_pc + ib;
                else if (in[14:12] > 3'd1)
                    bad = 1'b1;
            end
            default: begin
                if (in == 32'h0010_0073)
                    ebrk = 1'b1;
                else
                    bad = 1'b1;
            end
        endcase
        ld = (in[6:0] == 7'h03) && !bad;
        check("halt", bad || ebrk, halt);
        check("illegal", bad, illegal);
        check("dmem_wen", st, dmem_wen);
        check("dmem_ren", ld, dmem_ren);
        if (ld)
            check("dmem_addr", {ea[63:3], 3'b000}, dmem_addr);
        if (st) begin
            check("dmem_addr", {ea[63:3], 3'b000}, dmem_addr);
            check("dmem_wdata", wd, dmem_wdata);
            check("dmem_wmask", mask, dmem_wmask);
            for (int b = 0; b < 8; b++)
                if (mask[b])
                    m_mem[ea[11:3]][8*b +: 8] = wd[8*b +: 8];
        end
        if (bad || ebrk) begin
            m_halted = 1'b1;
        end else begin
            if (wr && in[11:7] != 5'd0)
                x[in[11:7]] = val;
            m_pc = npc;
        end
    endtask

    // falling edge, all DUT outputs settled
    always @(negedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                x[i] = '0;
            for (int i = 0; i < 512; i++)
                m_mem[i] = mem_fill(i);
            m_pc     = reset_pc;
            m_halted = 1'b0;
            first    = 1'b1;
        end else begin
            if (first) begin
                check("halt", 1'b0, halt);
                check("illegal", 1'b0, illegal);
                first = 1'b0;
            end
            check("imem_addr", m_pc, imem_addr);
            if (m_halted) begin
                check("halt", 1'b1, halt);
                check("dmem_wen", 1'b0, dmem_wen);
                check("dmem_ren", 1'b0, dmem_ren);
            end else begin
                step(imem_data);
            end
        end
    end

    task automatic end_test(input int num, input string kind);
        if (errors == errors_at_start) begin
            passes++;
            $display("test %0d (%s): pass", num, kind);
        end else begin
            fails++;
            $display("test %0d (%s): fail, %0d mismatches", num, kind,
                     errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask
endmodule

`default_nettype wire

//--- hw/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter core_pkg::xlen_t reset_pc = '0
) (
    input  wire                  clk,
    input  wire                  rst_n,
    output core_pkg::xlen_t      imem_addr,
    input  wire isa_pkg::inst_t  imem_data,
    output core_pkg::xlen_t      dmem_addr,
    output core_pkg::xlen_t      dmem_wdata,
    output core_pkg::wmask_t     dmem_wmask,
    output logic                 dmem_wen,
    output logic                 dmem_ren,
    input  wire core_pkg::xlen_t dmem_rdata,
    output logic                 halt,
    output logic                 illegal
);
    core_pkg::xlen_t pc;
    core_pkg::xlen_t rs1_data;
    core_pkg::xlen_t rs2_data;
    core_pkg::xlen_t alu_result;
    core_pkg::xlen_t load_data;
    core_pkg::xlen_t wb_data;
    logic            branch_taken;

    decode_if dec ();

    assign imem_addr = pc;
    assign illegal   = dec.illegal;
    assign wb_data   = dec.mem_read ? load_data : alu_result;

    inst_decoder inst_decoder_i (
        .imem_data (imem_data),
        .dec       (dec)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .dec      (dec),
        .wb_data  (wb_data),
        .halt     (halt),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu alu_i (
        .dec          (dec),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    mem_access mem_access_i (
        .dec        (dec),
        .addr       (alu_result),
        .rs2_data   (rs2_data),
        .halt       (halt),
        .dmem_rdata (dmem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wmask (dmem_wmask),
        .dmem_wen   (dmem_wen),
        .dmem_ren   (dmem_ren),
        .load_data  (load_data)
    );

    fetch_pc #(
        .reset_pc (reset_pc)
    ) fetch_pc_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec          (dec),
        .rs1_data     (rs1_data),
        .branch_taken (branch_taken),
        .pc           (pc),
        .halt         (halt)
    );
endmodule

`default_nettype wire

//--- hw/fetch_pc.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_pc #(
    parameter core_pkg::xlen_t reset_pc = '0
) (
    input  wire                  clk,
    input  wire                  rst_n,
    decode_if.datapath           dec,
    input  wire core_pkg::xlen_t rs1_data,
    input  wire                  branch_taken,
    output core_pkg::xlen_t      pc,
    output logic                 halt
);
    logic            halted;
    core_pkg::xlen_t next_pc;
    core_pkg::xlen_t jalr_target;

    assign halt        = halted | dec.illegal | dec.ebreak;
    assign jalr_target = rs1_data + dec.imm;

    always_comb begin
        if (halt)
            next_pc = pc;  // frozen until reset
        else if (dec.jump && !dec.jalr)
            next_pc = pc + dec.imm;
        else if (dec.jalr)
            next_pc = {jalr_target[63:1], 1'b0};
        else if (branch_taken)
            next_pc = pc + dec.imm;
        else
            next_pc = pc + 64'd4;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc     <= reset_pc;
            halted <= 1'b0;
        end else begin
            pc     <= next_pc;
            halted <= halt;
        end
    end
endmodule

`default_nettype wire

//--- hw/mem_access.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access (
    decode_if.datapath           dec,
    input  wire core_pkg::xlen_t addr,
    input  wire core_pkg::xlen_t rs2_data,
    input  wire                  halt,
    input  wire core_pkg::xlen_t dmem_rdata,
    output core_pkg::xlen_t      dmem_addr,
    output core_pkg::xlen_t      dmem_wdata,
    output core_pkg::wmask_t     dmem_wmask,
    output logic                 dmem_wen,
    output logic                 dmem_ren,
    output core_pkg::xlen_t      load_data
);
    logic [2:0]       byte_off;
    core_pkg::wmask_t lane_mask;
    core_pkg::xlen_t  rdata_sh;

    assign byte_off   = addr[2:0];
    assign dmem_addr  = {addr[63:3], 3'b000};
    assign dmem_wdata = rs2_data << {byte_off, 3'b000};  // into byte lanes
    assign dmem_wen   = dec.mem_write && !halt;
    assign dmem_ren   = dec.mem_read && !halt;
    assign dmem_wmask = dmem_wen ? lane_mask : '0;
    assign rdata_sh   = dmem_rdata >> {byte_off, 3'b000};

    always_comb begin
        case (dec.mem_size)
            core_pkg::size_byte: lane_mask = 8'h01 << byte_off;
            core_pkg::size_half: lane_mask = 8'h03 << byte_off;
            core_pkg::size_word: lane_mask = 8'h0f << byte_off;
            default:             lane_mask = 8'hff;
        endcase
    end

    always_comb begin
        case (dec.mem_size)
            core_pkg::size_byte:
                load_data = {{56{rdata_sh[7] & ~dec.load_unsigned}}, rdata_sh[7:0]};
            core_pkg::size_half:
                load_data = {{48{rdata_sh[15] & ~dec.load_unsigned}}, rdata_sh[15:0]};
            core_pkg::size_word:
                load_data = {{32{rdata_sh[31] & ~dec.load_unsigned}}, rdata_sh[31:0]};
            default:
                load_data = rdata_sh;
        endcase
    end
endmodule

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    decode_if.datapath           dec,
    input  wire core_pkg::xlen_t pc,
    input  wire core_pkg::xlen_t rs1_data,
    input  wire core_pkg::xlen_t rs2_data,
    output core_pkg::xlen_t      result,
    output logic                 branch_taken
);
    core_pkg::xlen_t op_a;
    core_pkg::xlen_t op_b;
    core_pkg::xlen_t raw;

    always_comb begin
        case (dec.alu_src)
            core_pkg::src_reg:    begin op_a = rs1_data; op_b = rs2_data; end
            core_pkg::src_imm:    begin op_a = rs1_data; op_b = dec.imm;  end
            core_pkg::src_pc_imm: begin op_a = pc;       op_b = dec.imm;  end
            default:              begin op_a = pc;       op_b = 64'd4;    end
        endcase
    end

    always_comb begin
        case (dec.alu_op)
            core_pkg::alu_sub:  raw = op_a - op_b;  // also bne compare
            core_pkg::alu_sltu: raw = {63'b0, op_a < op_b};
            core_pkg::alu_sra:  raw = $signed(op_a) >>> op_b[5:0];
            core_pkg::alu_eq:   raw = {63'b0, op_a == op_b};
            default:            raw = op_a + op_b;
        endcase
    end

    assign result = dec.word_op ? {{32{raw[31]}}, raw[31:0]} : raw;

    assign branch_taken = dec.branch && (result != '0);
endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                  clk,
    input  wire                  rst_n,
    decode_if.datapath           dec,
    input  wire core_pkg::xlen_t wb_data,
    input  wire                  halt,
    output core_pkg::xlen_t      rs1_data,
    output core_pkg::xlen_t      rs2_data
);
    core_pkg::xlen_t regs [31:1];  // x0 not stored

    assign rs1_data = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
    assign rs2_data = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (dec.reg_wen && !halt && dec.rd != '0) begin
            regs[dec.rd] <= wb_data;
        end
    end
endmodule

`default_nettype wire

//--- hw/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  wire isa_pkg::inst_t imem_data,
    decode_if.decoder           dec
);
    isa_pkg::opcode_t opcode;
    isa_pkg::funct3_t funct3;
    isa_pkg::funct7_t funct7;
    core_pkg::xlen_t  imm_i;
    core_pkg::xlen_t  imm_s;
    core_pkg::xlen_t  imm_b;
    core_pkg::xlen_t  imm_u;
    core_pkg::xlen_t  imm_j;

    assign opcode = imem_data[6:0];
    assign funct3 = imem_data[isa_pkg::funct3_lsb +: 3];
    assign funct7 = imem_data[isa_pkg::funct7_lsb +: 7];

    assign imm_i = {{52{imem_data[31]}}, imem_data[31:20]};
    assign imm_s = {{52{imem_data[31]}}, imem_data[31:25], imem_data[11:7]};
    assign imm_b = {{52{imem_data[31]}}, imem_data[7], imem_data[30:25],
                    imem_data[11:8], 1'b0};
    assign imm_u = {{32{imem_data[31]}}, imem_data[31:12], 12'b0};
    assign imm_j = {{44{imem_data[31]}}, imem_data[19:12], imem_data[20],
                    imem_data[30:21], 1'b0};

    always_comb begin
        dec.alu_op        = core_pkg::alu_add;
        dec.alu_src       = core_pkg::src_reg;
        dec.imm           = imm_i;
        dec.rs1           = imem_data[isa_pkg::rs1_lsb +: 5];
        dec.rs2           = imem_data[isa_pkg::rs2_lsb +: 5];
        dec.rd            = imem_data[isa_pkg::rd_lsb +: 5];
        dec.reg_wen       = 1'b0;
        dec.word_op       = 1'b0;
        dec.mem_read      = 1'b0;
        dec.mem_write     = 1'b0;
        dec.mem_size      = core_pkg::size_double;
        dec.load_unsigned = 1'b0;
        dec.branch        = 1'b0;
        dec.jump          = 1'b0;
        dec.jalr          = 1'b0;
        dec.illegal       = 1'b0;
        dec.ebreak        = 1'b0;

        case (opcode)
            isa_pkg::op_reg: begin
                dec.reg_wen = 1'b1;
                if (funct3 != isa_pkg::funct3_add)
                    dec.illegal = 1'b1;
                else if (funct7 == isa_pkg::funct7_sub)
                    dec.alu_op = core_pkg::alu_sub;
                else if (funct7 != isa_pkg::funct7_add)
                    dec.illegal = 1'b1;
            end
            isa_pkg::op_imm: begin
                dec.reg_wen = 1'b1;
                dec.alu_src = core_pkg::src_imm;
                case (funct3)
                    isa_pkg::funct3_add:  dec.alu_op = core_pkg::alu_add;
                    isa_pkg::funct3_sltu: dec.alu_op = core_pkg::alu_sltu;
                    isa_pkg::funct3_sra: begin
                        dec.alu_op = core_pkg::alu_sra;  // shamt in imm[5:0]
                        if (funct7[6:1] != isa_pkg::funct7_srai[6:1])
                            dec.illegal = 1'b1;
                    end
                    default: dec.illegal = 1'b1;
                endcase
            end
            isa_pkg::op_reg_w: begin
                dec.reg_wen = 1'b1;
                dec.word_op = 1'b1;
                if (funct3 != isa_pkg::funct3_add || funct7 != isa_pkg::funct7_add)
                    dec.illegal = 1'b1;
            end
            isa_pkg::op_imm_w: begin
                dec.reg_wen = 1'b1;
                dec.word_op = 1'b1;
                dec.alu_src = core_pkg::src_imm;
                if (funct3 != isa_pkg::funct3_add)
                    dec.illegal = 1'b1;
            end
            isa_pkg::op_load: begin
                dec.reg_wen  = 1'b1;
                dec.mem_read = 1'b1;
                dec.alu_src  = core_pkg::src_imm;
                case (funct3)
                    isa_pkg::funct3_lw: dec.mem_size = core_pkg::size_word;
                    isa_pkg::funct3_ld: dec.mem_size = core_pkg::size_double;
                    isa_pkg::funct3_lbu: begin
                        dec.mem_size      = core_pkg::size_byte;
                        dec.load_unsigned = 1'b1;
                    end
                    default: dec.illegal = 1'b1;
                endcase
            end
            isa_pkg::op_store: begin
                dec.mem_write = 1'b1;
                dec.alu_src   = core_pkg::src_imm;
                dec.imm       = imm_s;
                case (funct3)
                    isa_pkg::funct3_sd: dec.mem_size = core_pkg::size_double;
                    isa_pkg::funct3_sh: dec.mem_size = core_pkg::size_half;
                    default:            dec.illegal  = 1'b1;
                endcase
            end
            isa_pkg::op_jal: begin
                dec.reg_wen = 1'b1;
                dec.jump    = 1'b1;
                dec.alu_src = core_pkg::src_pc_four;  // link value
                dec.imm     = imm_j;
            end
            isa_pkg::op_jalr: begin
                dec.reg_wen = 1'b1;
                dec.jump    = 1'b1;
                dec.jalr    = 1'b1;
                dec.alu_src = core_pkg::src_pc_four;
                if (funct3 != isa_pkg::funct3_jalr)
                    dec.illegal = 1'b1;
            end
            isa_pkg::op_lui: begin
                dec.reg_wen = 1'b1;
                dec.rs1     = '0;  // x0 + imm
                dec.alu_src = core_pkg::src_imm;
                dec.imm     = imm_u;
            end
            isa_pkg::op_auipc: begin
                dec.reg_wen = 1'b1;
                dec.alu_src = core_pkg::src_pc_imm;
                dec.imm     = imm_u;
            end
            isa_pkg::op_branch: begin
                dec.branch = 1'b1;
                dec.imm    = imm_b;
                case (funct3)
                    isa_pkg::funct3_beq: dec.alu_op  = core_pkg::alu_eq;
                    isa_pkg::funct3_bne: dec.alu_op  = core_pkg::alu_sub;
                    default:             dec.illegal = 1'b1;
                endcase
            end
            default: begin
                if (imem_data == isa_pkg::ebreak_word)
                    dec.ebreak = 1'b1;
                else
                    dec.illegal = 1'b1;
            end
        endcase

        // no side effects from a bad encoding
        if (dec.illegal) begin
            dec.reg_wen   = 1'b0;
            dec.mem_read  = 1'b0;
            dec.mem_write = 1'b0;
            dec.branch    = 1'b0;
            dec.jump      = 1'b0;
            dec.jalr      = 1'b0;
        end
    end
endmodule

`default_nettype wire

//--- hw/decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_if;
    core_pkg::alu_op_t   alu_op;
    core_pkg::alu_src_t  alu_src;
    core_pkg::xlen_t     imm;
    core_pkg::reg_idx_t  rs1;
    core_pkg::reg_idx_t  rs2;
    core_pkg::reg_idx_t  rd;
    logic                reg_wen;
    logic                word_op;  // 32-bit result, sign-extended
    logic                mem_read;
    logic                mem_write;
    core_pkg::mem_size_t mem_size;
    logic                load_unsigned;
    logic                branch;
    logic                jump;     // jal and jalr
    logic                jalr;
    logic                illegal;
    logic                ebreak;

    modport decoder (
        output alu_op, alu_src, imm, rs1, rs2, rd, reg_wen, word_op,
               mem_read, mem_write, mem_size, load_unsigned,
               branch, jump, jalr, illegal, ebreak
    );

    modport datapath (
        input  alu_op, alu_src, imm, rs1, rs2, rd, reg_wen, word_op,
               mem_read, mem_write, mem_size, load_unsigned,
               branch, jump, jalr, illegal, ebreak
    );
endinterface

`default_nettype wire

//--- hw/core_pkg.sv
`default_nettype none

package core_pkg;
    typedef logic [63:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  alu_op_t;
    typedef logic [1:0]  alu_src_t;
    typedef logic [1:0]  mem_size_t;
    typedef logic [7:0]  wmask_t;

    localparam alu_op_t alu_add  = 3'd0;
    localparam alu_op_t alu_sub  = 3'd1;
    localparam alu_op_t alu_sltu = 3'd2;
    localparam alu_op_t alu_sra  = 3'd3;
    localparam alu_op_t alu_eq   = 3'd4;  // 1 when operands equal

    // operand pairs
    localparam alu_src_t src_reg     = 2'd0;  // rs1, rs2
    localparam alu_src_t src_imm     = 2'd1;  // rs1, imm
    localparam alu_src_t src_pc_imm  = 2'd2;  // pc, imm
    localparam alu_src_t src_pc_four = 2'd3;  // pc, 4

    localparam mem_size_t size_byte   = 2'd0;
    localparam mem_size_t size_half   = 2'd1;
    localparam mem_size_t size_word   = 2'd2;
    localparam mem_size_t size_double = 2'd3;
endpackage

`default_nettype wire

//--- hw/isa_pkg.sv
`default_nettype none

package isa_pkg;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [31:0] inst_t;

    localparam int rd_lsb     = 7;
    localparam int funct3_lsb = 12;
    localparam int rs1_lsb    = 15;
    localparam int rs2_lsb    = 20;
    localparam int funct7_lsb = 25;

    localparam opcode_t op_reg    = 7'b0110011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_reg_w  = 7'b0111011;
    localparam opcode_t op_imm_w  = 7'b0011011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_branch = 7'b1100011;

    localparam funct3_t funct3_add  = 3'b000;  // add, sub, addi, addw, addiw
    localparam funct3_t funct3_sltu = 3'b011;
    localparam funct3_t funct3_sra  = 3'b101;
    localparam funct3_t funct3_lw   = 3'b010;
    localparam funct3_t funct3_ld   = 3'b011;
    localparam funct3_t funct3_lbu  = 3'b100;
    localparam funct3_t funct3_sd   = 3'b011;
    localparam funct3_t funct3_sh   = 3'b001;
    localparam funct3_t funct3_jalr = 3'b000;
    localparam funct3_t funct3_beq  = 3'b000;
    localparam funct3_t funct3_bne  = 3'b001;

    localparam funct7_t funct7_add  = 7'b0000000;
    localparam funct7_t funct7_sub  = 7'b0100000;
    localparam funct7_t funct7_srai = 7'b0100000;  // bit 0 is shamt[5] on rv64

    localparam inst_t ebreak_word = 32'h0010_0073;
endpackage

`default_nettype wire
